//--- verilog/mx_pkg.sv
package mx_pkg;

    // Block geometry
    localparam int MAN_WIDTH  = 8;
    localparam int EXP_WIDTH  = 8;
    localparam int BLOCK_SIZE = 4;

    // Skip path buffering, at least straight latency plus 2
    localparam int SKIP_DEPTH = 8;
    localparam int SKIP_PTR_W = $clog2(SKIP_DEPTH);
    localparam int SKIP_CNT_W = $clog2(SKIP_DEPTH + 1);

    // Mantissa and exponent limits
    localparam logic signed [MAN_WIDTH-1:0] MAN_MAX = {1'b0, {(MAN_WIDTH-1){1'b1}}};
    localparam logic signed [MAN_WIDTH-1:0] MAN_MIN = {1'b1, {(MAN_WIDTH-1){1'b0}}};
    localparam logic [EXP_WIDTH-1:0]        EXP_MAX = {EXP_WIDTH{1'b1}};

    typedef enum logic [1:0] {
        OP_PASS   = 2'd0,
        OP_NEGATE = 2'd1,
        OP_DOUBLE = 2'd2,
        OP_ZERO   = 2'd3
    } mx_op_e;

    typedef logic signed [MAN_WIDTH-1:0] mx_man_t;

    // Element 0 sits in the low bits, exponent on top
    typedef struct packed {
        logic [EXP_WIDTH-1:0]     exp;
        mx_man_t [BLOCK_SIZE-1:0] man;
    } mx_block_t;

    typedef struct packed {
        mx_op_e    op;
        mx_block_t blk;
    } mx_cmd_t;

endpackage

//--- verilog/mx_sync_fifo.sv
module mx_sync_fifo
    import mx_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  mx_block_t wr_blk,
    input  logic      wr_en,
    output logic      full,
    output mx_block_t rd_blk,
    output logic      rd_valid,
    input  logic      rd_en
);

    mx_block_t             mem [SKIP_DEPTH];
    logic [SKIP_PTR_W-1:0] wr_ptr;
    logic [SKIP_PTR_W-1:0] rd_ptr;
    logic [SKIP_CNT_W-1:0] count;
    logic                  do_wr;
    logic                  do_rd;

    function automatic logic [SKIP_PTR_W-1:0] next_ptr(input logic [SKIP_PTR_W-1:0] ptr);
        if (ptr == SKIP_PTR_W'(SKIP_DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign full     = (count == SKIP_CNT_W'(SKIP_DEPTH));
    assign rd_valid = (count != '0);
    assign do_wr    = wr_en && !full;
    assign do_rd    = rd_en && rd_valid;

    // First word falls through
    assign rd_blk = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr_blk;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (do_rd) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    a_no_write_when_full: assert property (
        @(posedge clk) disable iff (!rst_n) !(wr_en && full)
    );

    a_no_read_when_empty: assert property (
        @(posedge clk) disable iff (!rst_n) !(rd_en && !rd_valid)
    );

endmodule

//--- verilog/mx_block_fork.sv
module mx_block_fork
    import mx_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,

    // Input stream
    input  mx_cmd_t   in_cmd,
    input  logic      in_valid,
    output logic      in_ready,

    // Straight copy, to the transform
    output mx_cmd_t   straight_cmd,
    output logic      straight_valid,
    input  logic      straight_ready,

    // Skip copy, to the join
    output mx_block_t skip_blk,
    output logic      skip_valid,
    input  logic      skip_ready
);

    logic fifo_full;
    logic straight_free;
    logic accept;

    // Straight register empty or draining this cycle
    assign straight_free = !straight_valid || straight_ready;

    // Both copies must have room, so they never drift apart
    assign in_ready = straight_free && !fifo_full;
    assign accept   = in_valid && in_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            straight_valid <= 1'b0;
        end else if (accept) begin
            straight_valid <= 1'b1;
        end else if (straight_ready) begin
            straight_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            straight_cmd <= in_cmd;
        end
    end

    // Opcode only matters on the straight path
    mx_sync_fifo skip_fifo_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .wr_blk   (in_cmd.blk),
        .wr_en    (accept),
        .full     (fifo_full),
        .rd_blk   (skip_blk),
        .rd_valid (skip_valid),
        .rd_en    (skip_valid && skip_ready)
    );

    // A straight copy in flight always has its skip partner queued
    a_skip_paired: assert property (
        @(posedge clk) disable iff (!rst_n) straight_valid |-> skip_valid
    );

endmodule

//--- verilog/mx_block_transform.sv
module mx_block_transform
    import mx_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,

    input  mx_cmd_t   in_cmd,
    input  logic      in_valid,
    output logic      in_ready,

    output mx_block_t out_blk,
    output logic      out_valid,
    input  logic      out_ready
);

    logic      s1_valid;
    mx_op_e    s1_op;
    mx_block_t s1_blk;
    mx_block_t s1_next;
    logic      s1_ready;
    logic      s1_load;
    logic      s2_load;

    // Each stage moves when the next one is empty or draining
    assign s1_ready = !out_valid || out_ready;
    assign in_ready = !s1_valid || s1_ready;
    assign s1_load  = in_valid && in_ready;
    assign s2_load  = s1_valid && s1_ready;

    // Stage 1 mantissa update
    always_comb begin
        s1_next = in_cmd.blk;
        for (int i = 0; i < BLOCK_SIZE; i++) begin
            case (in_cmd.op)
                OP_NEGATE: begin
                    if (in_cmd.blk.man[i] == MAN_MIN) begin
                        s1_next.man[i] = MAN_MAX;
                    end else begin
                        s1_next.man[i] = -$signed(in_cmd.blk.man[i]);
                    end
                end
                OP_ZERO: s1_next.man[i] = '0;
                default: s1_next.man[i] = in_cmd.blk.man[i];
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_valid  <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            if (s1_load) begin
                s1_valid <= 1'b1;
            end else if (s1_ready) begin
                s1_valid <= 1'b0;
            end
            if (s2_load) begin
                out_valid <= 1'b1;
            end else if (out_ready) begin
                out_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (s1_load) begin
            s1_op  <= in_cmd.op;
            s1_blk <= s1_next;
        end
        // Stage 2 exponent update, saturating on double
        if (s2_load) begin
            out_blk.man <= s1_blk.man;
            if (s1_op == OP_DOUBLE && s1_blk.exp != EXP_MAX) begin
                out_blk.exp <= s1_blk.exp + 1'b1;
            end else begin
                out_blk.exp <= s1_blk.exp;
            end
        end
    end

    a_op_known: assert property (
        @(posedge clk) disable iff (!rst_n)
        s1_valid |-> s1_op inside {OP_PASS, OP_NEGATE, OP_DOUBLE, OP_ZERO}
    );

endmodule

//--- verilog/mx_residual_join.sv
module mx_residual_join
    import mx_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,

    input  mx_block_t xf_blk,
    input  logic      xf_valid,
    output logic      xf_ready,

    input  mx_block_t skip_blk,
    input  logic      skip_valid,
    output logic      skip_ready,

    output mx_block_t out_blk,
    output logic      out_valid,
    input  logic      out_ready
);

    logic                        fire;
    logic                        xf_larger;
    logic [EXP_WIDTH-1:0]        common_exp;
    logic [EXP_WIDTH-1:0]        diff;
    logic signed [MAN_WIDTH:0]   sum [BLOCK_SIZE];
    logic                        any_ovf;
    mx_block_t                   result;

    // Arithmetic right shift, sign fill once the shift covers the whole mantissa
    function automatic mx_man_t align_man(input mx_man_t m, input logic [EXP_WIDTH-1:0] sh);
        if (sh >= EXP_WIDTH'(MAN_WIDTH)) begin
            return {MAN_WIDTH{m[MAN_WIDTH-1]}};
        end
        return $signed(m) >>> sh;
    endfunction

    function automatic mx_man_t clamp_man(input logic signed [MAN_WIDTH:0] s);
        if (s > $signed({MAN_MAX[MAN_WIDTH-1], MAN_MAX})) begin
            return MAN_MAX;
        end
        if (s < $signed({MAN_MIN[MAN_WIDTH-1], MAN_MIN})) begin
            return MAN_MIN;
        end
        return s[MAN_WIDTH-1:0];
    endfunction

    // Take one item from each side in the same cycle
    assign fire       = xf_valid && skip_valid && (!out_valid || out_ready);
    assign xf_ready   = fire;
    assign skip_ready = fire;

    assign xf_larger  = (xf_blk.exp >= skip_blk.exp);
    assign common_exp = xf_larger ? xf_blk.exp : skip_blk.exp;
    assign diff       = xf_larger ? (xf_blk.exp - skip_blk.exp) : (skip_blk.exp - xf_blk.exp);

    always_comb begin
        any_ovf = 1'b0;
        for (int i = 0; i < BLOCK_SIZE; i++) begin
            sum[i] = $signed(align_man(xf_blk.man[i], xf_larger ? '0 : diff))
                   + $signed(align_man(skip_blk.man[i], xf_larger ? diff : '0));
            // Guard bit disagrees with sign bit
            if (sum[i][MAN_WIDTH] != sum[i][MAN_WIDTH-1]) begin
                any_ovf = 1'b1;
            end
        end
    end

    // Renormalise, or clamp when the exponent cannot grow
    always_comb begin
        result.exp = common_exp;
        for (int i = 0; i < BLOCK_SIZE; i++) begin
            result.man[i] = sum[i][MAN_WIDTH-1:0];
        end
        if (any_ovf) begin
            if (common_exp != EXP_MAX) begin
                result.exp = common_exp + 1'b1;
                for (int i = 0; i < BLOCK_SIZE; i++) begin
                    result.man[i] = sum[i][MAN_WIDTH:1];
                end
            end else begin
                for (int i = 0; i < BLOCK_SIZE; i++) begin
                    result.man[i] = clamp_man(sum[i]);
                end
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else if (fire) begin
            out_valid <= 1'b1;
        end else if (out_ready) begin
            out_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (fire) begin
            out_blk <= result;
        end
    end

    // A transformed block always finds its skip partner waiting
    a_skip_present: assert property (
        @(posedge clk) disable iff (!rst_n) xf_valid |-> skip_valid
    );

endmodule

//--- verilog/mx_residual_unit.sv
module mx_residual_unit
    import mx_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,

    input  mx_cmd_t   in_cmd,
    input  logic      in_valid,
    output logic      in_ready,

    output mx_block_t out_blk,
    output logic      out_valid,
    input  logic      out_ready
);

    mx_cmd_t   straight_cmd;
    logic      straight_valid;
    logic      straight_ready;
    mx_block_t skip_blk;
    logic      skip_valid;
    logic      skip_ready;
    mx_block_t xf_blk;
    logic      xf_valid;
    logic      xf_ready;

    mx_block_fork block_fork_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .in_cmd         (in_cmd),
        .in_valid       (in_valid),
        .in_ready       (in_ready),
        .straight_cmd   (straight_cmd),
        .straight_valid (straight_valid),
        .straight_ready (straight_ready),
        .skip_blk       (skip_blk),
        .skip_valid     (skip_valid),
        .skip_ready     (skip_ready)
    );

    mx_block_transform block_transform_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_cmd    (straight_cmd),
        .in_valid  (straight_valid),
        .in_ready  (straight_ready),
        .out_blk   (xf_blk),
        .out_valid (xf_valid),
        .out_ready (xf_ready)
    );

    // Skip and transformed blocks meet here
    mx_residual_join residual_join_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .xf_blk     (xf_blk),
        .xf_valid   (xf_valid),
        .xf_ready   (xf_ready),
        .skip_blk   (skip_blk),
        .skip_valid (skip_valid),
        .skip_ready (skip_ready),
        .out_blk    (out_blk),
        .out_valid  (out_valid),
        .out_ready  (out_ready)
    );

endmodule

//--- test/mx_residual_checker.sv
module mx_residual_checker
    import mx_pkg::*;
(
    input  logic            clk,
    input  logic            rst_n,
    input  mx_cmd_t         in_cmd,
    input  logic            in_valid,
    input  logic            in_ready,
    input  mx_block_t       out_blk,
    input  logic            out_valid,
    input  logic            out_ready,
    input  logic [8*12-1:0] test_name,
    input  logic            lat_check,
    output int              checked,
    output int              errors,
    output int              pending
);

    timeunit 1ns;
    timeprecision 1ps;

    mx_block_t       exp_q [$];
    logic [8*12-1:0] name_q [$];
    int              cyc_q [$];
    bit              lat_q [$];
    int              cycle;

    // Arithmetic shift, all sign once the shift reaches the mantissa width
    function automatic int shift_down(input int m, input int sh);
        if (sh >= MAN_WIDTH) begin
            return (m < 0) ? -1 : 0;
        end
        return m >>> sh;
    endfunction

    function automatic mx_block_t expected_result(input mx_cmd_t c);
        int        hi;
        int        lo;
        int        emax;
        int        xe;
        int        se;
        int        e;
        int        xm [BLOCK_SIZE];
        int        s [BLOCK_SIZE];
        bit        ovf;
        mx_block_t r;
        hi   = 2 ** (MAN_WIDTH - 1) - 1;
        lo   = -(2 ** (MAN_WIDTH - 1));
        emax = 2 ** EXP_WIDTH - 1;
        se   = c.blk.exp;
        xe   = se;
        ovf  = 0;
        if (c.op == OP_DOUBLE && xe < emax) begin
            xe = xe + 1;
        end
        for (int i = 0; i < BLOCK_SIZE; i++) begin
            xm[i] = $signed(c.blk.man[i]);
            if (c.op == OP_NEGATE) begin
                xm[i] = (-xm[i] > hi) ? hi : -xm[i];
            end else if (c.op == OP_ZERO) begin
                xm[i] = 0;
            end
        end
        e = (xe > se) ? xe : se;
        for (int i = 0; i < BLOCK_SIZE; i++) begin
            s[i] = shift_down(xm[i], e - xe) + shift_down($signed(c.blk.man[i]), e - se);
            if (s[i] > hi || s[i] < lo) begin
                ovf = 1;
            end
        end
        if (ovf && e < emax) begin
            e = e + 1;
            for (int i = 0; i < BLOCK_SIZE; i++) begin
                s[i] = s[i] >>> 1;
            end
        end else if (ovf) begin
            for (int i = 0; i < BLOCK_SIZE; i++) begin
                s[i] = (s[i] > hi) ? hi : ((s[i] < lo) ? lo : s[i]);
            end
        end
        r.exp = e[EXP_WIDTH-1:0];
        for (int i = 0; i < BLOCK_SIZE; i++) begin
            r.man[i] = s[i][MAN_WIDTH-1:0];
        end
        return r;
    endfunction

    // Handshakes are settled by mid-cycle, transfer follows at the next rising edge
    always @(negedge clk or negedge rst_n) begin
        mx_block_t       e;
        logic [8*12-1:0] n;
        int              c;
        bit              l;
        if (!rst_n) begin
            checked = 0;
            errors  = 0;
            cycle   = 0;
            exp_q.delete();
            name_q.delete();
            cyc_q.delete();
            lat_q.delete();
        end else begin
            cycle++;
            // Nothing may stall the input while the output never pushes back
            if (lat_check && in_valid && !in_ready) begin
                $display("Mismatch in %0s in_ready: expected 1, actual 0", string'(test_name));
                errors++;
            end
            if (in_valid && in_ready) begin
                exp_q.push_back(expected_result(in_cmd));
                name_q.push_back(test_name);
                cyc_q.push_back(cycle);
                lat_q.push_back(lat_check);
            end
            if (out_valid && out_ready) begin
                if (exp_q.size() == 0) begin
                    $display("Error: output block %h came out with no input pending", out_blk);
                    errors++;
                end else begin
                    e = exp_q.pop_front();
                    n = name_q.pop_front();
                    c = cyc_q.pop_front();
                    l = lat_q.pop_front();
                    checked++;
                    if (out_blk !== e) begin
                        $display("Mismatch in %0s: expected %h, actual %h", string'(n), e, out_blk);
                        errors++;
                    end
                    if (l && (cycle - c) != 4) begin
                        $display("Mismatch in %0s latency: expected 4, actual %0d",
                                 string'(n), cycle - c);
                        errors++;
                    end
                end
            end
        end
        pending = exp_q.size();
    end

endmodule

//--- test/tb_mx_residual_unit.sv
module tb_mx_residual_unit
    import mx_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int N_STIM     = 8;
    localparam int N_RAND     = 48;
    localparam int WAIT_LIMIT = 200;

    typedef struct packed {
        logic [8*12-1:0]      name;
        mx_op_e               op;
        logic [EXP_WIDTH-1:0] exp;
        logic [MAN_WIDTH-1:0] man0;
        logic [MAN_WIDTH-1:0] man1;
        logic [MAN_WIDTH-1:0] man2;
        logic [MAN_WIDTH-1:0] man3;
    } stim_t;

    localparam stim_t STIM [N_STIM] = '{
        '{"pass_basic",  OP_PASS,   8'd20,  8'sd100, -8'sd100, 8'sd5,    -8'sd3},
        '{"pass_small",  OP_PASS,   8'd3,   8'sd1,   -8'sd1,   8'sd0,    8'sd2},
        '{"negate_sat",  OP_NEGATE, 8'd40,  8'sd80,  8'h80,    8'sd0,    -8'sd7},
        '{"double_mid",  OP_DOUBLE, 8'd10,  8'sd64,  -8'sd64,  8'sd3,    -8'sd3},
        '{"double_max",  OP_DOUBLE, 8'd255, 8'sd127, 8'h80,    8'sd100,  -8'sd1},
        '{"zero_block",  OP_ZERO,   8'd77,  8'sd12,  -8'sd34,  8'sd56,   -8'sd78},
        '{"pass_limits", OP_PASS,   8'd0,   8'sd127, 8'h80,    8'sd1,    -8'sd1},
        '{"double_odd",  OP_DOUBLE, 8'd200, 8'sd127, -8'sd127, -8'sd1,   8'sd1}
    };

    logic            clk;
    logic            rst_n;
    mx_cmd_t         in_cmd;
    logic            in_valid;
    logic            in_ready;
    mx_block_t       out_blk;
    logic            out_valid;
    logic            out_ready;
    logic [8*12-1:0] cur_name;
    logic            lat_check;
    logic            rand_bp;
    int              seed;
    int              tb_errors;
    int              checked;
    int              errors;
    int              pending;
    mx_cmd_t         rnd_cmd [N_RAND];

    mx_residual_unit dut_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_cmd    (in_cmd),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .out_blk   (out_blk),
        .out_valid (out_valid),
        .out_ready (out_ready)
    );

    mx_residual_checker checker_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_cmd    (in_cmd),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .out_blk   (out_blk),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .test_name (cur_name),
        .lat_check (lat_check),
        .checked   (checked),
        .errors    (errors),
        .pending   (pending)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Output back-pressure, random only in the stall phase
    initial begin
        out_ready = 1'b1;
        forever begin
            @(posedge clk);
            #1;
            out_ready = rand_bp ? ($random(seed) & 1) : 1'b1;
        end
    end

    function automatic mx_cmd_t cmd_from_stim(input stim_t s);
        mx_cmd_t c;
        c.op         = s.op;
        c.blk.exp    = s.exp;
        c.blk.man[0] = s.man0;
        c.blk.man[1] = s.man1;
        c.blk.man[2] = s.man2;
        c.blk.man[3] = s.man3;
        return c;
    endfunction

    // Called at posedge plus 1 ns, returns at posedge plus 1 ns after the transfer
    task automatic send_cmd(input logic [8*12-1:0] name, input mx_cmd_t cmd);
        int   waited;
        logic took;
        waited   = 0;
        took     = 1'b0;
        in_cmd   = cmd;
        cur_name = name;
        in_valid = 1'b1;
        while (!took && waited < WAIT_LIMIT) begin
            @(negedge clk);
            took = in_ready;
            @(posedge clk);
            #1;
            waited++;
        end
        if (!took) begin
            $display("Error: in_ready stayed low too long while sending %0s", string'(name));
            tb_errors++;
            in_valid = 1'b0;
        end
    endtask

    task automatic drain_outputs();
        int waited;
        waited   = 0;
        in_valid = 1'b0;
        while (pending != 0 && waited < WAIT_LIMIT) begin
            @(posedge clk);
            waited++;
        end
        if (pending != 0) begin
            $display("Error: timeout, %0d expected output blocks never came out", pending);
            tb_errors++;
        end
        repeat (4) @(posedge clk);
        #1;
    endtask

    initial begin
        logic [63:0] r;
        seed      = 32'h0449_44e5;
        rst_n     = 1'b0;
        in_cmd    = '0;
        in_valid  = 1'b0;
        cur_name  = '0;
        lat_check = 1'b1;
        rand_bp   = 1'b0;
        tb_errors = 0;
        for (int i = 0; i < N_RAND; i++) begin
            r = {$random(seed), $random(seed)};
            rnd_cmd[i] = r[$bits(mx_cmd_t)-1:0];
        end
        repeat (8) @(posedge clk);
        #1;
        rst_n = 1'b1;
        @(posedge clk);
        #1;

        // Directed table, output always ready, fixed latency
        for (int i = 0; i < N_STIM; i++) begin
            send_cmd(STIM[i].name, cmd_from_stim(STIM[i]));
        end
        drain_outputs();

        // Same table plus random blocks under back-pressure
        lat_check = 1'b0;
        rand_bp   = 1'b1;
        for (int i = 0; i < N_STIM; i++) begin
            send_cmd(STIM[i].name, cmd_from_stim(STIM[i]));
        end
        for (int i = 0; i < N_RAND; i++) begin
            send_cmd("random_mix", rnd_cmd[i]);
        end
        drain_outputs();
        rand_bp = 1'b0;

        $display("Summary: %0d blocks checked, %0d checker errors, %0d testbench errors",
                 checked, errors, tb_errors);
        if (errors == 0 && tb_errors == 0 && checked == 2 * N_STIM + N_RAND) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

//--- src.f
verilog/mx_pkg.sv
verilog/mx_sync_fifo.sv
verilog/mx_block_fork.sv
verilog/mx_block_transform.sv
verilog/mx_residual_join.sv
verilog/mx_residual_unit.sv
test/mx_residual_checker.sv
test/tb_mx_residual_unit.sv

//--- Bender.yml
package:
  name: mx_residual_unit

sources:
  - verilog/mx_pkg.sv
  - verilog/mx_sync_fifo.sv
  - verilog/mx_block_fork.sv
  - verilog/mx_block_transform.sv
  - verilog/mx_residual_join.sv
  - verilog/mx_residual_unit.sv
  - target: test
    files:
      - test/mx_residual_checker.sv
      - test/tb_mx_residual_unit.sv
